// File: hw/bp_defs.svh
// Branch predictor sizing
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// width of fetch and resolve addresses
`define BP_PC_WIDTH 32

// gshare index width
// the global history register has the same width
// 1024 entries
`define BP_GSHARE_BITS 10

// bimodal index width
// 512 entries
`define BP_BIMODAL_BITS 9

// chooser index width
// 512 entries
`define BP_CHOOSER_BITS 9

// every index starts above the word offset in pc
// instructions are word aligned so bits 1 and 0 carry nothing

`endif

// File: hw/bp_pkg.sv
// Branch predictor counter types
package bp_pkg;

  // 2-bit saturating counter
  // 0 and 1 mean not taken, 2 and 3 mean taken
  // in the chooser a set msb means prefer gshare
  typedef logic [1:0] ctr_t;

  // every counter comes out of reset weakly high
  localparam ctr_t CTR_WEAK_HI = 2'd2;

  // saturation limits
  localparam ctr_t CTR_MAX = 2'd3;
  localparam ctr_t CTR_MIN = 2'd0;

  // step one toward strongly high, hold at 3
  function automatic ctr_t ctr_up(input ctr_t c);
    ctr_t r;
    r = c;
    if (c != CTR_MAX) begin
      r = c + 2'd1;
    end
    return r;
  endfunction

  // step one toward strongly low, hold at 0
  function automatic ctr_t ctr_down(input ctr_t c);
    ctr_t r;
    r = c;
    if (c != CTR_MIN) begin
      r = c - 2'd1;
    end
    return r;
  endfunction

endpackage

// File: hw/gshare_predictor.sv
// Gshare direction predictor
`timescale 1ns/100ps

`include "bp_defs.svh"

module gshare_predictor import bp_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  // fetch lookup address
  input  logic [`BP_PC_WIDTH-1:0] pc,
  // resolved branches from execute
  // first slot is the older one
  input  logic [`BP_PC_WIDTH-1:0] res_pc_first,
  input  logic                    res_valid_first,
  input  logic                    res_taken_first,
  input  logic [`BP_PC_WIDTH-1:0] res_pc_second,
  input  logic                    res_valid_second,
  input  logic                    res_taken_second,
  // guess for pc and per-slot correctness
  output logic                    guess,
  output logic                    correct_first,
  output logic                    correct_second
);

  localparam int BITS    = `BP_GSHARE_BITS;
  localparam int ENTRIES = 1 << BITS;

  // pattern history table
  ctr_t pht [ENTRIES];

  // global history, newest outcome in bit 0
  logic [BITS-1:0] history;
  logic [BITS-1:0] history_next;

  logic [BITS-1:0] idx_lookup;
  logic [BITS-1:0] idx_first;
  logic [BITS-1:0] idx_second;

  ctr_t ctr_first;
  ctr_t ctr_second;
  ctr_t next_first;
  ctr_t base_second;
  ctr_t next_second;
  logic same_entry;

  // pc above the word offset hashed with start-of-cycle history
  assign idx_lookup = pc[BITS+1:2] ^ history;
  assign idx_first  = res_pc_first[BITS+1:2] ^ history;
  assign idx_second = res_pc_second[BITS+1:2] ^ history;

  // msb of the counter is the direction
  assign guess = pht[idx_lookup][1];

  // counters before this cycle's training
  assign ctr_first  = pht[idx_first];
  assign ctr_second = pht[idx_second];

  assign correct_first  = (ctr_first[1] == res_taken_first);
  assign correct_second = (ctr_second[1] == res_taken_second);

  // older slot steps first
  assign next_first = res_taken_first ? ctr_up(ctr_first) : ctr_down(ctr_first);

  // younger slot builds on the older result when both hit one entry
  assign same_entry  = res_valid_first && (idx_first == idx_second);
  assign base_second = same_entry ? next_first : ctr_second;
  assign next_second = res_taken_second ? ctr_up(base_second) : ctr_down(base_second);

  // shift in valid outcomes, older one first
  always_comb begin
    case ({res_valid_first, res_valid_second})
      2'b11: history_next = {history[BITS-3:0], res_taken_first, res_taken_second};
      2'b10: history_next = {history[BITS-2:0], res_taken_first};
      2'b01: history_next = {history[BITS-2:0], res_taken_second};
      default: history_next = history;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      history <= '0;
      for (int i = 0; i < ENTRIES; i++) begin
        pht[i] <= CTR_WEAK_HI;
      end
    end else begin
      history <= history_next;
      if (res_valid_first) begin
        pht[idx_first] <= next_first;
      end
      // same-entry case already folds in the first step
      // so the later write carries both
      if (res_valid_second) begin
        pht[idx_second] <= next_second;
      end
    end
  end

  // resolved pc drives the write index on a valid slot
  a_pc_first_known: assert property (@(posedge clk) disable iff (reset)
    res_valid_first |-> !$isunknown(res_pc_first));

  a_pc_second_known: assert property (@(posedge clk) disable iff (reset)
    res_valid_second |-> !$isunknown(res_pc_second));

  // once cleared by reset the history must stay known
  a_history_known: assert property (@(posedge clk) disable iff (reset)
    $past(reset) || !$isunknown($past(history)) |-> !$isunknown(history));

endmodule

// File: hw/bimodal_predictor.sv
// Bimodal direction predictor
`timescale 1ns/100ps

`include "bp_defs.svh"

module bimodal_predictor import bp_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  // fetch lookup address
  input  logic [`BP_PC_WIDTH-1:0] pc,
  // resolved branches from execute
  // first slot is the older one
  input  logic [`BP_PC_WIDTH-1:0] res_pc_first,
  input  logic                    res_valid_first,
  input  logic                    res_taken_first,
  input  logic [`BP_PC_WIDTH-1:0] res_pc_second,
  input  logic                    res_valid_second,
  input  logic                    res_taken_second,
  // guess for pc and per-slot correctness
  output logic                    guess,
  output logic                    correct_first,
  output logic                    correct_second
);

  localparam int BITS    = `BP_BIMODAL_BITS;
  localparam int ENTRIES = 1 << BITS;

  // per-pc counters
  ctr_t bht [ENTRIES];

  logic [BITS-1:0] idx_lookup;
  logic [BITS-1:0] idx_first;
  logic [BITS-1:0] idx_second;

  ctr_t ctr_first;
  ctr_t ctr_second;
  ctr_t next_first;
  ctr_t base_second;
  ctr_t next_second;
  logic same_entry;

  // plain pc index above the word offset
  assign idx_lookup = pc[BITS+1:2];
  assign idx_first  = res_pc_first[BITS+1:2];
  assign idx_second = res_pc_second[BITS+1:2];

  assign guess = bht[idx_lookup][1];

  // read before this cycle's update
  assign ctr_first  = bht[idx_first];
  assign ctr_second = bht[idx_second];

  assign correct_first  = (ctr_first[1] == res_taken_first);
  assign correct_second = (ctr_second[1] == res_taken_second);

  assign next_first = res_taken_first ? ctr_up(ctr_first) : ctr_down(ctr_first);

  // chain the two steps when both slots land on one counter
  assign same_entry  = res_valid_first && (idx_first == idx_second);
  assign base_second = same_entry ? next_first : ctr_second;
  assign next_second = res_taken_second ? ctr_up(base_second) : ctr_down(base_second);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < ENTRIES; i++) begin
        bht[i] <= CTR_WEAK_HI;
      end
    end else begin
      if (res_valid_first) begin
        bht[idx_first] <= next_first;
      end
      if (res_valid_second) begin
        bht[idx_second] <= next_second;
      end
    end
  end

  // outcome picks the step direction
  a_taken_first_known: assert property (@(posedge clk) disable iff (reset)
    res_valid_first |-> !$isunknown(res_taken_first));

  a_taken_second_known: assert property (@(posedge clk) disable iff (reset)
    res_valid_second |-> !$isunknown(res_taken_second));

endmodule

// File: hw/tournament_chooser.sv
// Tournament chooser
`timescale 1ns/100ps

`include "bp_defs.svh"

module tournament_chooser import bp_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  // fetch lookup address
  input  logic [`BP_PC_WIDTH-1:0] pc,
  // resolved branch addresses and strobes
  input  logic [`BP_PC_WIDTH-1:0] res_pc_first,
  input  logic [`BP_PC_WIDTH-1:0] res_pc_second,
  input  logic                    res_valid_first,
  input  logic                    res_valid_second,
  // component guesses for pc
  input  logic                    gshare_guess,
  input  logic                    bimodal_guess,
  // component correctness on the resolved slots
  input  logic                    gshare_correct_first,
  input  logic                    gshare_correct_second,
  input  logic                    bimodal_correct_first,
  input  logic                    bimodal_correct_second,
  // final direction
  output logic                    pred
);

  localparam int BITS    = `BP_CHOOSER_BITS;
  localparam int ENTRIES = 1 << BITS;

  // selector counters
  // high half prefers gshare
  ctr_t sel [ENTRIES];

  logic [BITS-1:0] idx_lookup;
  logic [BITS-1:0] idx_first;
  logic [BITS-1:0] idx_second;

  ctr_t sel_first;
  ctr_t next_first;
  ctr_t base_second;
  ctr_t next_second;
  logic same_entry;

  // move toward whichever component was right alone
  // agreement leaves the counter where it is
  function automatic ctr_t train(input ctr_t c, input logic g_ok, input logic b_ok);
    ctr_t r;
    r = c;
    if (g_ok && !b_ok) begin
      r = ctr_up(c);
    end else if (!g_ok && b_ok) begin
      r = ctr_down(c);
    end
    return r;
  endfunction

  assign idx_lookup = pc[BITS+1:2];
  assign idx_first  = res_pc_first[BITS+1:2];
  assign idx_second = res_pc_second[BITS+1:2];

  // pass the preferred component's guess straight through
  assign pred = sel[idx_lookup][1] ? gshare_guess : bimodal_guess;

  assign sel_first  = sel[idx_first];
  assign next_first = train(sel_first, gshare_correct_first, bimodal_correct_first);

  // second slot sees the first slot's result on a shared entry
  assign same_entry  = res_valid_first && (idx_first == idx_second);
  assign base_second = same_entry ? next_first : sel[idx_second];
  assign next_second = train(base_second, gshare_correct_second, bimodal_correct_second);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < ENTRIES; i++) begin
        sel[i] <= CTR_WEAK_HI;
      end
    end else begin
      if (res_valid_first) begin
        sel[idx_first] <= next_first;
      end
      if (res_valid_second) begin
        sel[idx_second] <= next_second;
      end
    end
  end

  // flags come from both predictors and steer the selector update
  a_correct_first_known: assert property (@(posedge clk) disable iff (reset)
    res_valid_first |-> !$isunknown({gshare_correct_first, bimodal_correct_first}));

  a_correct_second_known: assert property (@(posedge clk) disable iff (reset)
    res_valid_second |-> !$isunknown({gshare_correct_second, bimodal_correct_second}));

endmodule

// File: hw/branch_predictor_top.sv
// Branch direction predictor top
`timescale 1ns/100ps

`include "bp_defs.svh"

module branch_predictor_top (
  input  logic                    clk,
  input  logic                    reset,
  // fetch lookup address
  input  logic [`BP_PC_WIDTH-1:0] pc,
  // two resolution slots from execute
  input  logic [`BP_PC_WIDTH-1:0] res_pc_first,
  input  logic                    res_valid_first,
  input  logic                    res_taken_first,
  input  logic [`BP_PC_WIDTH-1:0] res_pc_second,
  input  logic                    res_valid_second,
  input  logic                    res_taken_second,
  // taken guess for pc
  output logic                    pred
);

  // component guesses
  logic gshare_guess;
  logic bimodal_guess;

  // component correctness for chooser training
  logic gshare_correct_first;
  logic gshare_correct_second;
  logic bimodal_correct_first;
  logic bimodal_correct_second;

  gshare_predictor u_gshare (
    .clk              (clk),
    .reset            (reset),
    .pc               (pc),
    .res_pc_first     (res_pc_first),
    .res_valid_first  (res_valid_first),
    .res_taken_first  (res_taken_first),
    .res_pc_second    (res_pc_second),
    .res_valid_second (res_valid_second),
    .res_taken_second (res_taken_second),
    .guess            (gshare_guess),
    .correct_first    (gshare_correct_first),
    .correct_second   (gshare_correct_second)
  );

  bimodal_predictor u_bimodal (
    .clk              (clk),
    .reset            (reset),
    .pc               (pc),
    .res_pc_first     (res_pc_first),
    .res_valid_first  (res_valid_first),
    .res_taken_first  (res_taken_first),
    .res_pc_second    (res_pc_second),
    .res_valid_second (res_valid_second),
    .res_taken_second (res_taken_second),
    .guess            (bimodal_guess),
    .correct_first    (bimodal_correct_first),
    .correct_second   (bimodal_correct_second)
  );

  tournament_chooser u_chooser (
    .clk                    (clk),
    .reset                  (reset),
    .pc                     (pc),
    .res_pc_first           (res_pc_first),
    .res_pc_second          (res_pc_second),
    .res_valid_first        (res_valid_first),
    .res_valid_second       (res_valid_second),
    .gshare_guess           (gshare_guess),
    .bimodal_guess          (bimodal_guess),
    .gshare_correct_first   (gshare_correct_first),
    .gshare_correct_second  (gshare_correct_second),
    .bimodal_correct_first  (bimodal_correct_first),
    .bimodal_correct_second (bimodal_correct_second),
    .pred                   (pred)
  );

endmodule

// File: tb/tb_branch_predictor.sv
// Branch predictor testbench
`timescale 1ns/100ps

`include "bp_defs.svh"

module tb_branch_predictor;

  localparam int PW = `BP_PC_WIDTH;
  localparam int GB = `BP_GSHARE_BITS;
  localparam int BB = `BP_BIMODAL_BITS;
  localparam int CB = `BP_CHOOSER_BITS;

  logic          clk = 1'b0;
  logic          reset = 1'b1;
  logic [PW-1:0] pc = '0;
  logic [PW-1:0] res_pc_first = '0;
  logic          res_valid_first = 1'b0;
  logic          res_taken_first = 1'b0;
  logic [PW-1:0] res_pc_second = '0;
  logic          res_valid_second = 1'b0;
  logic          res_taken_second = 1'b0;
  logic          pred;

  // golden copies of the three tables and the history
  logic [1:0]    gsh_tab [1 << GB];
  logic [1:0]    bim_tab [1 << BB];
  logic [1:0]    chs_tab [1 << CB];
  logic [GB-1:0] hist;

  int seed = 32;
  int error_count = 0;

  branch_predictor_top uut (
    .clk              (clk),
    .reset            (reset),
    .pc               (pc),
    .res_pc_first     (res_pc_first),
    .res_valid_first  (res_valid_first),
    .res_taken_first  (res_taken_first),
    .res_pc_second    (res_pc_second),
    .res_valid_second (res_valid_second),
    .res_taken_second (res_taken_second),
    .pred             (pred)
  );

  // 10 ns clock
  always #5 clk = ~clk;

  // 2-bit saturating step, up on taken
  function automatic logic [1:0] sat_step(input logic [1:0] c, input logic up);
    logic [1:0] r;
    r = c;
    if (up && c != 2'd3) begin
      r = c + 2'd1;
    end else if (!up && c != 2'd0) begin
      r = c - 2'd1;
    end
    return r;
  endfunction

  // selector moves only when exactly one component was right
  function automatic logic [1:0] select_step(input logic [1:0] c, input logic g_ok,
                                             input logic b_ok);
    logic [1:0] r;
    r = c;
    if (g_ok && !b_ok) begin
      r = sat_step(c, 1'b1);
    end else if (!g_ok && b_ok) begin
      r = sat_step(c, 1'b0);
    end
    return r;
  endfunction

  // expected direction for a lookup pc
  function automatic logic model_predict(input logic [PW-1:0] p);
    logic g;
    logic b;
    g = gsh_tab[p[GB+1:2] ^ hist][1];
    b = bim_tab[p[BB+1:2]][1];
    return chs_tab[p[CB+1:2]][1] ? g : b;
  endfunction

  // pc that reaches under the current history the gshare entry p reached under h
  function automatic logic [PW-1:0] gshare_alias_pc(input logic [PW-1:0] p,
                                                    input logic [GB-1:0] h);
    logic [PW-1:0] d;
    d = '0;
    d[GB+1:2] = h ^ hist;
    return p ^ d;
  endfunction

  task automatic model_clear();
    for (int i = 0; i < (1 << GB); i++) begin
      gsh_tab[i] = 2'd2;
    end
    for (int i = 0; i < (1 << BB); i++) begin
      bim_tab[i] = 2'd2;
    end
    for (int i = 0; i < (1 << CB); i++) begin
      chs_tab[i] = 2'd2;
    end
    hist = '0;
  endtask

  // apply one cycle of resolutions to the model
  task automatic model_resolve(input logic v1, input logic t1, input logic [PW-1:0] p1,
                               input logic v2, input logic t2, input logic [PW-1:0] p2);
    logic [GB-1:0] gi1;
    logic [GB-1:0] gi2;
    logic [BB-1:0] bi1;
    logic [BB-1:0] bi2;
    logic [CB-1:0] ci1;
    logic [CB-1:0] ci2;
    logic          g_ok1;
    logic          g_ok2;
    logic          b_ok1;
    logic          b_ok2;
    // both slots index with start-of-cycle history
    gi1 = p1[GB+1:2] ^ hist;
    gi2 = p2[GB+1:2] ^ hist;
    bi1 = p1[BB+1:2];
    bi2 = p2[BB+1:2];
    ci1 = p1[CB+1:2];
    ci2 = p2[CB+1:2];
    // correctness uses counters from before any update
    g_ok1 = (gsh_tab[gi1][1] == t1);
    g_ok2 = (gsh_tab[gi2][1] == t2);
    b_ok1 = (bim_tab[bi1][1] == t1);
    b_ok2 = (bim_tab[bi2][1] == t2);
    // older slot first, so a shared entry sees both steps
    if (v1) begin
      gsh_tab[gi1] = sat_step(gsh_tab[gi1], t1);
      bim_tab[bi1] = sat_step(bim_tab[bi1], t1);
      chs_tab[ci1] = select_step(chs_tab[ci1], g_ok1, b_ok1);
      hist = {hist[GB-2:0], t1};
    end
    if (v2) begin
      gsh_tab[gi2] = sat_step(gsh_tab[gi2], t2);
      bim_tab[bi2] = sat_step(bim_tab[bi2], t2);
      chs_tab[ci2] = select_step(chs_tab[ci2], g_ok2, b_ok2);
      hist = {hist[GB-2:0], t2};
    end
  endtask

  task automatic check_pred(input logic [PW-1:0] p, input logic exp);
    assert (pred === exp) else begin
      error_count++;
      $display("** Error: pred for pc %h is %h, expected %h", p, pred, exp);
      $display("Done: errors found");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // one cycle: lookup checked against the model, then training
  task automatic run_cycle(input logic [PW-1:0] look,
                           input logic v1, input logic t1, input logic [PW-1:0] p1,
                           input logic v2, input logic t2, input logic [PW-1:0] p2);
    @(negedge clk);
    pc = look;
    res_valid_first = v1;
    res_taken_first = t1;
    res_pc_first = p1;
    res_valid_second = v2;
    res_taken_second = t2;
    res_pc_second = p2;
    #1;
    check_pred(look, model_predict(look));
    model_resolve(v1, t1, p1, v2, t2, p2);
    @(posedge clk);
  endtask

  // lookup only, against a fixed expectation
  task automatic lookup_expect(input logic [PW-1:0] look, input logic exp);
    @(negedge clk);
    pc = look;
    res_valid_first = 1'b0;
    res_valid_second = 1'b0;
    #1;
    check_pred(look, exp);
  endtask

  task automatic wait_pred_taken();
    int waited;
    waited = 0;
    pc = '0;
    #1;
    while (pred !== 1'b1) begin
      if (waited >= 4) begin
        error_count++;
        $display("pred did not return to taken within 4 cycles after reset");
        $display("Done: errors found");
        $fatal(1, "reset wait timed out");
      end
      @(negedge clk);
      #1;
      waited++;
    end
  endtask

  // reset held over 3 rising edges
  task automatic apply_reset();
    reset = 1'b1;
    res_valid_first = 1'b0;
    res_valid_second = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    model_clear();
    wait_pred_taken();
  endtask

  // mostly full-width pcs, sometimes a tiny pool to force aliasing
  function automatic logic [PW-1:0] pick_pc();
    logic [PW-1:0] r;
    r = $random(seed);
    if (r[31]) begin
      r = r & 32'h0000_007c;
    end
    return r;
  endfunction

  // every gshare entry comes out of reset weakly taken
  task automatic test_reset_sweep();
    for (int i = 0; i < (1 << GB); i++) begin
      lookup_expect({20'h0, i[9:0], 2'b00}, 1'b1);
    end
  endtask

  task automatic test_saturation();
    logic [PW-1:0] a;
    logic [GB-1:0] h;
    a = 32'h0000_0400;
    // history stays zero while only not-taken shifts in
    for (int i = 0; i < 4; i++) begin
      run_cycle(a, 1'b1, 1'b0, a, 1'b0, 1'b0, '0);
    end
    lookup_expect(a, 1'b0);
    run_cycle(a, 1'b1, 1'b0, a, 1'b0, 1'b0, '0);
    run_cycle(a, 1'b1, 1'b0, a, 1'b0, 1'b0, '0);
    // single taken after saturation
    h = hist;
    run_cycle(a, 1'b1, 1'b1, a, 1'b0, 1'b0, '0);
    // the taken outcome moved history, so look at the trained entry through an alias
    lookup_expect(gshare_alias_pc(a, h), 1'b0);
    run_cycle(a, 1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
  endtask

  task automatic test_same_entry();
    logic [PW-1:0] c;
    logic [GB-1:0] h;
    c = 32'h0000_0808;
    // each follow-up lookup reaches the entry both slots just trained
    h = hist;
    run_cycle(c, 1'b1, 1'b1, c, 1'b1, 1'b0, c);
    run_cycle(gshare_alias_pc(c, h), 1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
    h = hist;
    run_cycle(c, 1'b1, 1'b0, c, 1'b1, 1'b1, c);
    run_cycle(gshare_alias_pc(c, h), 1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
    h = hist;
    run_cycle(c, 1'b1, 1'b0, c, 1'b1, 1'b0, c);
    run_cycle(gshare_alias_pc(c, h), 1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
  endtask

  // N T N T at one pc, only history can separate the two cases
  task automatic test_alternating();
    logic [PW-1:0] b;
    logic          t;
    b = 32'h0000_0f30;
    for (int i = 0; i < 48; i++) begin
      t = i[0];
      // after training the guess must match the coming outcome
      if (i >= 40) begin
        lookup_expect(b, t);
      end
      run_cycle(b, 1'b1, t, b, 1'b0, 1'b0, '0);
    end
  endtask

  task automatic test_random_stream();
    logic [PW-1:0] r;
    logic [PW-1:0] p1;
    logic [PW-1:0] p2;
    logic [PW-1:0] look;
    for (int i = 0; i < 2000; i++) begin
      r = $random(seed);
      p1 = pick_pc();
      // same pc in both slots now and then
      p2 = r[4] ? p1 : pick_pc();
      look = r[5] ? p1 : pick_pc();
      run_cycle(look, r[0], r[2], p1, r[1], r[3], p2);
    end
  endtask

  task automatic test_mid_run_reset();
    @(negedge clk);
    apply_reset();
    for (int i = 0; i < 64; i++) begin
      lookup_expect(pick_pc(), 1'b1);
    end
    run_cycle(32'h0000_0400, 1'b1, 1'b0, 32'h0000_0400, 1'b0, 1'b0, '0);
    run_cycle(32'h0000_0400, 1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
  endtask

  initial begin
    apply_reset();
    test_reset_sweep();
    test_saturation();
    test_same_entry();
    test_alternating();
    test_random_stream();
    test_mid_run_reset();
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: branch_predictor.f
+incdir+hw
hw/bp_pkg.sv
hw/gshare_predictor.sv
hw/bimodal_predictor.sv
hw/tournament_chooser.sv
hw/branch_predictor_top.sv
tb/tb_branch_predictor.sv

// File: Makefile
# Verilator build and run for the branch predictor

SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_branch_predictor
FILELIST = branch_predictor.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) hw/bp_defs.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "Done: no errors" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
